// ==== flist.f ====
hdl/rename_pkg.sv
hdl/mapping_table.sv
hdl/free_list.sv
hdl/rat.sv
hdl/rename_stage.sv
dv/rename_stage_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module rename_stage_tb \
		-Mdir obj_dir -o rename_sim

run: compile
	./obj_dir/rename_sim | tee run.log
	grep -q "^\*\* PASS \*\*$$" run.log

clean:
	rm -rf obj_dir run.log

// ==== dv/rename_stage_tb.sv ====
`timescale 1ns/1ns

module rename_stage_tb import rename_pkg::*; ();

  logic                         clock = 1'b0;
  logic                         reset;
  logic                         pause;
  logic                         recover;
  micro_op_t                    recover_uop;
  logic                         resolve;
  commit_t                      commit;
  micro_op_t [rename_width-1:0] uop_in;
  micro_op_t [rename_width-1:0] uop_out;
  logic                         allocatable;
  logic                         checkable;

  int          checks;
  int          errors;
  int          tests_done;

  ////////////////////
  // Reference model
  ////////////////////

  // Speculative map and free queue with unbounded pointers
  preg_t     ref_map [arch_regs];
  preg_t     ref_fl_mem [fl_entries];
  int        ref_fl_head;
  int        ref_fl_tail;
  // Checkpointed map and free head after each branch group
  preg_t     ref_cp_map [cp_entries][arch_regs];
  int        ref_cp_fl_head [cp_entries];
  int        ref_cp_head;
  int        ref_cp_tail;
  int        ref_cp_count;
  // Expected uop_out after the last register update
  micro_op_t last_exp [rename_width];

  rename_stage i_dut (
    .clock       (clock),
    .reset       (reset),
    .pause       (pause),
    .recover     (recover),
    .recover_uop (recover_uop),
    .resolve     (resolve),
    .commit      (commit),
    .uop_in      (uop_in),
    .uop_out     (uop_out),
    .allocatable (allocatable),
    .checkable   (checkable)
  );

  always #5 clock = ~clock;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  function automatic areg_t rand_areg();
    // Arch reg 0 is never renamed
    return areg_t'($urandom_range(31, 1));
  endfunction

  function automatic micro_op_t make_uop(input logic branch, input logic dest,
                                         input areg_t src1, input areg_t src2,
                                         input areg_t dst);
    micro_op_t u;
    u           = '0;
    u.valid     = 1'b1;
    u.is_branch = branch;
    u.has_dest  = dest;
    u.arch_src1 = src1;
    u.arch_src2 = src2;
    u.arch_dest = dst;
    return u;
  endfunction

  task automatic check_out();
    for (int k = 0; k < rename_width; k++) begin
      check_value($sformatf("uop_out[%0d].valid", k), uop_out[k].valid, last_exp[k].valid);
      if (last_exp[k].valid) begin
        check_value($sformatf("uop_out[%0d].phys_src1", k), uop_out[k].phys_src1,
                    last_exp[k].phys_src1);
        check_value($sformatf("uop_out[%0d].phys_src2", k), uop_out[k].phys_src2,
                    last_exp[k].phys_src2);
        check_value($sformatf("uop_out[%0d].phys_dest", k), uop_out[k].phys_dest,
                    last_exp[k].phys_dest);
        check_value($sformatf("uop_out[%0d].old_phys_dest", k), uop_out[k].old_phys_dest,
                    last_exp[k].old_phys_dest);
        // cp_id only means something on a branch
        if (last_exp[k].is_branch) begin
          check_value($sformatf("uop_out[%0d].cp_id", k), uop_out[k].cp_id,
                      last_exp[k].cp_id);
        end
      end
    end
  endtask

  task automatic check_status();
    check_value("allocatable", allocatable, 32'((ref_fl_tail - ref_fl_head) >= rename_width));
    check_value("checkable", checkable, 32'(ref_cp_count < cp_entries));
  endtask

  task automatic reset_dut();
    @(posedge clock);
    reset       <= 1'b1;
    pause       <= 1'b0;
    recover     <= 1'b0;
    recover_uop <= '0;
    resolve     <= 1'b0;
    commit      <= '0;
    uop_in      <= '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    // Identity map with 32 to 63 free in order
    for (int a = 0; a < arch_regs; a++) begin
      ref_map[a] = preg_t'(a);
    end
    for (int f = 0; f < fl_entries; f++) begin
      ref_fl_mem[f] = preg_t'(arch_regs + f);
    end
    ref_fl_head  = 0;
    ref_fl_tail  = fl_entries;
    ref_cp_head  = 0;
    ref_cp_tail  = 0;
    ref_cp_count = 0;
    for (int k = 0; k < rename_width; k++) begin
      last_exp[k] = '0;
    end
    @(negedge clock);
  endtask

  // Upstream presents a group only with both flags high
  task automatic wait_ready();
    int n;
    n = 0;
    while (!(allocatable && checkable) && n < 50) begin
      @(negedge clock);
      n++;
    end
    if (!(allocatable && checkable)) begin
      errors++;
      $display("At %0t ns allocatable or checkable stayed low for 50 cycles", $time);
    end
  endtask

  // Presents one group and checks it one cycle later with optional pause cycles
  task automatic rename_group(input micro_op_t g0, input micro_op_t g1, input int hold);
    micro_op_t g [rename_width];
    logic      took_cp;
    g[0]    = g0;
    g[1]    = g1;
    took_cp = 1'b0;
    wait_ready();
    @(posedge clock);
    uop_in[0] <= g0;
    uop_in[1] <= g1;
    // Slots in order so slot 1 sees slot 0's write
    for (int k = 0; k < rename_width; k++) begin
      last_exp[k]               = g[k];
      last_exp[k].phys_src1     = ref_map[g[k].arch_src1];
      last_exp[k].phys_src2     = ref_map[g[k].arch_src2];
      last_exp[k].phys_dest     = '0;
      last_exp[k].old_phys_dest = '0;
      last_exp[k].cp_id         = cp_bits'(ref_cp_tail);
      if (g[k].valid && g[k].has_dest && g[k].arch_dest != '0) begin
        last_exp[k].old_phys_dest = ref_map[g[k].arch_dest];
        last_exp[k].phys_dest     = ref_fl_mem[ref_fl_head % fl_entries];
        ref_fl_head++;
        ref_map[g[k].arch_dest] = last_exp[k].phys_dest;
      end
      if (g[k].valid && g[k].is_branch) begin
        took_cp = 1'b1;
      end
    end
    // Snapshot includes the group's own writes
    if (took_cp) begin
      for (int a = 0; a < arch_regs; a++) begin
        ref_cp_map[ref_cp_tail][a] = ref_map[a];
      end
      ref_cp_fl_head[ref_cp_tail] = ref_fl_head;
      ref_cp_tail  = (ref_cp_tail + 1) % cp_entries;
      ref_cp_count++;
    end
    @(posedge clock);
    // Group stays on uop_in while paused and must be ignored
    if (hold > 0) begin
      pause <= 1'b1;
    end else begin
      uop_in <= '0;
    end
    @(negedge clock);
    check_out();
    repeat (hold) begin
      @(posedge clock);
      @(negedge clock);
      check_out();
    end
    if (hold > 0) begin
      @(posedge clock);
      pause  <= 1'b0;
      uop_in <= '0;
      @(negedge clock);
    end
  endtask

  task automatic commit_reg(input preg_t p);
    commit_t c;
    c.valid         = 1'b1;
    c.old_phys_dest = p;
    @(posedge clock);
    commit <= c;
    ref_fl_mem[ref_fl_tail % fl_entries] = p;
    ref_fl_tail++;
    @(posedge clock);
    commit <= '0;
    @(negedge clock);
    check_status();
  endtask

  task automatic resolve_branch();
    @(posedge clock);
    resolve <= 1'b1;
    ref_cp_head = (ref_cp_head + 1) % cp_entries;
    ref_cp_count--;
    @(posedge clock);
    resolve <= 1'b0;
    @(negedge clock);
    check_status();
  endtask

  task automatic recover_branch(input logic [cp_bits-1:0] id);
    micro_op_t r;
    r       = '0;
    r.cp_id = id;
    @(posedge clock);
    recover     <= 1'b1;
    recover_uop <= r;
    // Map and head go back but releases since then stay queued
    for (int a = 0; a < arch_regs; a++) begin
      ref_map[a] = ref_cp_map[id][a];
    end
    ref_fl_head  = ref_cp_fl_head[id];
    ref_cp_count = ((int'(id) - ref_cp_head + cp_entries) % cp_entries) + 1;
    ref_cp_tail  = (int'(id) + 1) % cp_entries;
    for (int k = 0; k < rename_width; k++) begin
      last_exp[k] = '0;
    end
    @(posedge clock);
    recover <= 1'b0;
    @(negedge clock);
    check_out();
    check_status();
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_done++;
    $display("test %s %s, %0d errors", name,
             (errors == errors_before) ? "ok" : "failed", errors - errors_before);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic reset_lookup();
    int start;
    start = errors;
    reset_dut();
    check_out();
    check_status();
    rename_group(make_uop(1'b0, 1'b0, 5'd1, 5'd5, 5'd0), '0, 0);
    check_value("uop_out[0].phys_src1", uop_out[0].phys_src1, 1);
    check_value("uop_out[0].phys_src2", uop_out[0].phys_src2, 5);
    report_test("reset_lookup", start);
  endtask

  task automatic in_order_alloc();
    int start;
    start = errors;
    reset_dut();
    // Small register range so mappings get replaced often
    repeat (4) begin
      rename_group(make_uop(1'b0, 1'b1, rand_areg(), rand_areg(),
                            areg_t'($urandom_range(4, 1))),
                   make_uop(1'b0, 1'b1, rand_areg(), rand_areg(),
                            areg_t'($urandom_range(4, 1))), 0);
    end
    report_test("in_order_alloc", start);
  endtask

  task automatic group_bypass();
    int start;
    start = errors;
    reset_dut();
    rename_group(make_uop(1'b0, 1'b1, 5'd3, 5'd4, 5'd7),
                 make_uop(1'b0, 1'b1, 5'd7, 5'd2, 5'd7), 0);
    check_value("uop_out[1].phys_src1", uop_out[1].phys_src1, 32);
    check_value("uop_out[1].old_phys_dest", uop_out[1].old_phys_dest, 32);
    report_test("group_bypass", start);
  endtask

  task automatic free_list_wrap();
    int    start;
    preg_t first_old;
    start = errors;
    reset_dut();
    rename_group(make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()),
                 make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()), 0);
    first_old = last_exp[0].old_phys_dest;
    repeat (14) begin
      rename_group(make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()),
                   make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()), 0);
      check_status();
    end
    // One register left after this group
    rename_group(make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()), '0, 0);
    check_status();
    check_value("allocatable", allocatable, 0);
    commit_reg(first_old);
    check_value("allocatable", allocatable, 1);
    // Slot 1 takes the first entry after the wrap
    rename_group(make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()),
                 make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()), 0);
    check_value("uop_out[1].phys_dest", uop_out[1].phys_dest, first_old);
    report_test("free_list_wrap", start);
  endtask

  task automatic branch_recovery();
    int                 start;
    logic [cp_bits-1:0] id;
    start = errors;
    reset_dut();
    rename_group(make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()),
                 make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()), 0);
    // Branch in the last valid slot
    rename_group(make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()),
                 make_uop(1'b1, 1'b0, rand_areg(), rand_areg(), 5'd0), 0);
    id = last_exp[1].cp_id;
    repeat (3) begin
      rename_group(make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()),
                   make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()), 0);
    end
    recover_branch(id);
    // Read back every architectural register
    for (int r = 0; r < arch_regs / 4; r++) begin
      rename_group(make_uop(1'b0, 1'b0, areg_t'(4 * r), areg_t'(4 * r + 1), 5'd0),
                   make_uop(1'b0, 1'b0, areg_t'(4 * r + 2), areg_t'(4 * r + 3), 5'd0), 0);
    end
    rename_group(make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()),
                 make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()), 0);
    report_test("branch_recovery", start);
  endtask

  task automatic checkpoint_full_pause();
    int start;
    start = errors;
    reset_dut();
    repeat (cp_entries) begin
      rename_group(make_uop(1'b1, 1'b1, rand_areg(), rand_areg(), rand_areg()), '0, 0);
      check_status();
    end
    check_value("checkable", checkable, 0);
    resolve_branch();
    check_value("checkable", checkable, 1);
    // uop_out held for 3 paused cycles
    rename_group(make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()),
                 make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()), 3);
    // Free head must not have moved while paused
    rename_group(make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()),
                 make_uop(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg()), 0);
    report_test("checkpoint_full_pause", start);
  endtask

  ////////////////////
  // Main and watchdog
  ////////////////////

  initial begin
    void'($urandom(32'h7ae));
    checks     = 0;
    errors     = 0;
    tests_done = 0;
    reset       <= 1'b1;
    pause       <= 1'b0;
    recover     <= 1'b0;
    recover_uop <= '0;
    resolve     <= 1'b0;
    commit      <= '0;
    uop_in      <= '0;
    reset_lookup();
    in_order_alloc();
    group_bypass();
    free_list_wrap();
    branch_recovery();
    checkpoint_full_pause();
    $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Six tests of at most 200 cycles at 10 ns
  initial begin
    #(6 * 200 * 10);
    $display("Watchdog expired at %0t ns before the tests finished", $time);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== hdl/rename_stage.sv ====
`timescale 1ns/1ns

module rename_stage import rename_pkg::*; (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          pause,
  input  logic                          recover,
  input  micro_op_t                     recover_uop,
  input  logic                          resolve,
  input  commit_t                       commit,
  input  micro_op_t [rename_width-1:0]  uop_in,
  output micro_op_t [rename_width-1:0]  uop_out,
  output logic                          allocatable,
  output logic                          checkable
);

  // Rename control to free list
  logic [1:0]                   alloc_req;
  preg_t [rename_width-1:0]     alloc_preg;
  logic [fl_ptr_bits-1:0]       free_count;
  logic [fl_ptr_bits-1:0]       fl_head;
  logic                         release_en;
  preg_t                        release_preg;
  logic                         restore;
  logic [fl_ptr_bits-1:0]       restore_head;

  rat u_rat (
    .clock        (clock),
    .reset        (reset),
    .pause        (pause),
    .recover      (recover),
    .recover_uop  (recover_uop),
    .resolve      (resolve),
    .commit       (commit),
    .uop_in       (uop_in),
    .uop_out      (uop_out),
    .allocatable  (allocatable),
    .checkable    (checkable),
    .alloc_req    (alloc_req),
    .alloc_preg   (alloc_preg),
    .free_count   (free_count),
    .fl_head      (fl_head),
    .release_en   (release_en),
    .release_preg (release_preg),
    .restore      (restore),
    .restore_head (restore_head)
  );

  free_list u_free_list (
    .clock        (clock),
    .reset        (reset),
    .alloc_req    (alloc_req),
    .alloc_preg   (alloc_preg),
    .release_en   (release_en),
    .release_preg (release_preg),
    .restore      (restore),
    .restore_head (restore_head),
    .head         (fl_head),
    .free_count   (free_count)
  );

endmodule

// ==== hdl/rat.sv ====
`timescale 1ns/1ns

module rat import rename_pkg::*; (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          pause,
  input  logic                          recover,
  input  micro_op_t                     recover_uop,
  input  logic                          resolve,
  input  commit_t                       commit,
  input  micro_op_t [rename_width-1:0]  uop_in,
  output micro_op_t [rename_width-1:0]  uop_out,
  output logic                          allocatable,
  output logic                          checkable,
  // Free list side
  output logic [1:0]                    alloc_req,
  input  preg_t     [rename_width-1:0]  alloc_preg,
  input  logic [fl_ptr_bits-1:0]        free_count,
  input  logic [fl_ptr_bits-1:0]        fl_head,
  output logic                          release_en,
  output preg_t                         release_preg,
  output logic                          restore,
  output logic [fl_ptr_bits-1:0]        restore_head
);

  // Group taken this cycle
  logic                                 accept;
  logic      [rename_width-1:0]         need_dest;
  logic                                 take_cp;

  // Mapping table connections
  preg_t     [rename_width-1:0]         new_dest;
  preg_t     [rename_width-1:0][1:0]    src_phys;
  preg_t     [rename_width-1:0]         old_dest;
  map_t                                 next_map;
  map_t                                 restore_map;

  micro_op_t [rename_width-1:0]         renamed;

  // Checkpoint table
  map_t                                 cp_map [cp_entries];
  logic      [fl_ptr_bits-1:0]          cp_fl_head [cp_entries];
  logic      [cp_bits-1:0]              cp_head_q;
  logic      [cp_bits-1:0]              cp_tail_q;
  logic      [cp_bits:0]                cp_count_q;
  // Live entries from the oldest up to the recovered one
  logic      [cp_bits-1:0]              cp_keep;

  ////////////////////
  // Accept and allocate
  ////////////////////

  // Recover drops the group and pause holds it upstream
  assign accept = ~pause & ~recover;

  // Arch reg 0 stays on physical 0 and takes no register
  always_comb begin
    take_cp = 1'b0;
    for (int i = 0; i < rename_width; i++) begin
      need_dest[i] = accept & uop_in[i].valid & uop_in[i].has_dest &
                     (uop_in[i].arch_dest != '0);
      take_cp      = take_cp | (accept & uop_in[i].valid & uop_in[i].is_branch);
    end
  end

  assign alloc_req = 2'(need_dest[0]) + 2'(need_dest[1]);

  // Slot 1 takes the second register only when slot 0 used the first
  assign new_dest[0] = alloc_preg[0];
  assign new_dest[1] = need_dest[0] ? alloc_preg[1] : alloc_preg[0];

  mapping_table u_mapping_table (
    .clock       (clock),
    .reset       (reset),
    .lookup      (uop_in),
    .new_dest    (new_dest),
    .write_en    (need_dest),
    .src_phys    (src_phys),
    .old_dest    (old_dest),
    .next_map    (next_map),
    .restore     (restore),
    .restore_map (restore_map)
  );

  // Renamed group ahead of the output register
  always_comb begin
    for (int i = 0; i < rename_width; i++) begin
      renamed[i]               = uop_in[i];
      renamed[i].valid         = uop_in[i].valid;
      renamed[i].phys_src1     = src_phys[i][0];
      renamed[i].phys_src2     = src_phys[i][1];
      renamed[i].phys_dest     = need_dest[i] ? new_dest[i] : '0;
      renamed[i].old_phys_dest = need_dest[i] ? old_dest[i] : '0;
      // Branch owns the entry at the tail
      renamed[i].cp_id         = cp_tail_q;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      uop_out <= '0;
    end else if (recover) begin
      // Wrong-path group never leaves
      for (int i = 0; i < rename_width; i++) begin
        uop_out[i].valid <= 1'b0;
      end
    end else if (!pause) begin
      uop_out <= renamed;
    end
  end

  ////////////////////
  // Commit release
  ////////////////////

  // Physical 0 belongs to arch 0 for good
  assign release_en   = commit.valid & (commit.old_phys_dest != '0);
  assign release_preg = commit.old_phys_dest;

  ////////////////////
  // Checkpoints
  ////////////////////

  // Map and head as they stand after the branch group
  always_ff @(posedge clock) begin
    if (take_cp) begin
      cp_map[cp_tail_q]     <= next_map;
      cp_fl_head[cp_tail_q] <= fl_head + fl_ptr_bits'(alloc_req);
    end
  end

  assign restore      = recover;
  assign restore_map  = cp_map[recover_uop.cp_id];
  assign restore_head = cp_fl_head[recover_uop.cp_id];

  assign cp_keep = recover_uop.cp_id - cp_head_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      cp_head_q  <= '0;
      cp_tail_q  <= '0;
      cp_count_q <= '0;
    end else begin
      // Oldest branch proved correct
      if (resolve) begin
        cp_head_q <= cp_head_q + 1'b1;
      end
      if (recover) begin
        // Younger entries go and the recovered one stays
        cp_tail_q  <= recover_uop.cp_id + 1'b1;
        cp_count_q <= (cp_bits + 1)'(cp_keep) + 1'b1 - (cp_bits + 1)'(resolve);
      end else begin
        cp_tail_q  <= cp_tail_q + cp_bits'(take_cp);
        cp_count_q <= cp_count_q + (cp_bits + 1)'(take_cp) - (cp_bits + 1)'(resolve);
      end
    end
  end

  ////////////////////
  // Status
  ////////////////////

  // Enough for a full group of destinations
  assign allocatable = free_count >= fl_ptr_bits'(rename_width);
  assign checkable   = cp_count_q < (cp_bits + 1)'(cp_entries);

endmodule

// ==== hdl/free_list.sv ====
`timescale 1ns/1ns

module free_list import rename_pkg::*; (
  input  logic                          clock,
  input  logic                          reset,
  // Allocate, 0 to 2 registers per cycle
  input  logic [1:0]                    alloc_req,
  output preg_t [rename_width-1:0]      alloc_preg,
  // Release from commit
  input  logic                          release_en,
  input  preg_t                         release_preg,
  // Head restore on recovery
  input  logic                          restore,
  input  logic [fl_ptr_bits-1:0]        restore_head,
  output logic [fl_ptr_bits-1:0]        head,
  output logic [fl_ptr_bits-1:0]        free_count
);

  // Circular queue of free register numbers
  preg_t queue_q [fl_entries];

  // Pointers carry a wrap bit above the index
  logic [fl_ptr_bits-1:0] head_q;
  logic [fl_ptr_bits-1:0] tail_q;

  // Queue indices without the wrap bit
  logic [fl_ptr_bits-2:0] head_idx;
  logic [fl_ptr_bits-2:0] head_idx1;
  logic [fl_ptr_bits-2:0] tail_idx;

  assign head_idx  = head_q[fl_ptr_bits-2:0];
  // Wraps around the 32 entries on its own
  assign head_idx1 = head_idx + 1'b1;
  assign tail_idx  = tail_q[fl_ptr_bits-2:0];

  ////////////////////
  // Allocate
  ////////////////////

  // Two candidates straight off the head
  // Caller takes only as many as it asks for
  assign alloc_preg[0] = queue_q[head_idx];
  assign alloc_preg[1] = queue_q[head_idx1];

  assign head = head_q;

  // Entries between head and tail, wrap bit handles full
  assign free_count = tail_q - head_q;

  ////////////////////
  // Pointers and queue
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // Registers above the arch set start free, in order
      for (int i = 0; i < fl_entries; i++) begin
        queue_q[i] <= preg_t'(arch_regs + i);
      end
      head_q <= '0;
      // Full queue, tail one lap ahead of head
      tail_q <= fl_ptr_bits'(fl_entries);
    end else begin
      // Head jumps back to the checkpoint on recovery
      if (restore) begin
        head_q <= restore_head;
      end else begin
        head_q <= head_q + fl_ptr_bits'(alloc_req);
      end
      // Releases still land at the tail during a restore
      if (release_en) begin
        queue_q[tail_idx] <= release_preg;
        tail_q            <= tail_q + 1'b1;
      end
    end
  end

endmodule

// ==== hdl/mapping_table.sv ====
`timescale 1ns/1ns

module mapping_table import rename_pkg::*; (
  input  logic                              clock,
  input  logic                              reset,
  // Group being renamed this cycle
  input  micro_op_t [rename_width-1:0]      lookup,
  input  preg_t     [rename_width-1:0]      new_dest,
  input  logic      [rename_width-1:0]      write_en,
  // Per slot, index 0 is src1 and index 1 is src2
  output preg_t     [rename_width-1:0][1:0] src_phys,
  output preg_t     [rename_width-1:0]      old_dest,
  // Map after this group's writes
  output map_t                              next_map,
  // Checkpoint restore
  input  logic                              restore,
  input  map_t                              restore_map
);

  // Current speculative map
  map_t map_q;

  ////////////////////
  // Group lookup
  ////////////////////

  always_comb begin
    for (int i = 0; i < rename_width; i++) begin
      // Start from the stored map
      src_phys[i][0] = map_q[lookup[i].arch_src1];
      src_phys[i][1] = map_q[lookup[i].arch_src2];
      old_dest[i]    = map_q[lookup[i].arch_dest];
      // Older slots in the group win over the map
      // Youngest older writer applied last
      for (int j = 0; j < i; j++) begin
        if (write_en[j]) begin
          if (lookup[j].arch_dest == lookup[i].arch_src1) begin
            src_phys[i][0] = new_dest[j];
          end
          if (lookup[j].arch_dest == lookup[i].arch_src2) begin
            src_phys[i][1] = new_dest[j];
          end
          // Same dest twice, slot i replaces slot j's register
          if (lookup[j].arch_dest == lookup[i].arch_dest) begin
            old_dest[i] = new_dest[j];
          end
        end
      end
    end
  end

  ////////////////////
  // Map update
  ////////////////////

  // Writes applied in slot order so the last writer stays
  always_comb begin
    next_map = map_q;
    for (int i = 0; i < rename_width; i++) begin
      if (write_en[i]) begin
        next_map[lookup[i].arch_dest] = new_dest[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // Identity mapping, arch i on physical i
      for (int i = 0; i < arch_regs; i++) begin
        map_q[i] <= preg_t'(i);
      end
    end else if (restore) begin
      // Restore overrides any group write
      map_q <= restore_map;
    end else begin
      map_q <= next_map;
    end
  end

endmodule

// ==== hdl/rename_pkg.sv ====
package rename_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Micro-ops renamed per cycle
  localparam int rename_width = 2;

  // Architectural and physical register counts
  localparam int arch_regs = 32;
  localparam int phys_regs = 64;

  // Register number widths
  localparam int preg_bits = 6;
  localparam int areg_bits = 5;

  // Branch checkpoint table
  localparam int cp_entries = 4;
  localparam int cp_bits    = 2;

  // Free list holds every register not in the map
  localparam int fl_entries  = phys_regs - arch_regs;
  // Index bits plus one wrap bit
  localparam int fl_ptr_bits = 6;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [preg_bits-1:0] preg_t;
  typedef logic [areg_bits-1:0] areg_t;

  // One micro-op as it moves through rename
  typedef struct packed {
    logic               valid;
    logic               is_branch;
    logic               has_dest;
    areg_t              arch_src1;
    areg_t              arch_src2;
    areg_t              arch_dest;
    // Filled in by rename
    preg_t              phys_src1;
    preg_t              phys_src2;
    preg_t              phys_dest;
    // Mapping replaced by phys_dest, freed at commit
    preg_t              old_phys_dest;
    logic [cp_bits-1:0] cp_id;
  } micro_op_t;

  // Commit returns one physical register per cycle
  typedef struct packed {
    logic  valid;
    preg_t old_phys_dest;
  } commit_t;

  // Whole speculative map, entry i is the physical of arch reg i
  typedef preg_t [arch_regs-1:0] map_t;

endpackage
